/* include/rob_config.svh */
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// entries in the reorder buffer
// must stay a power of two, the pointers wrap on their own width
`define ROB_DEPTH 16

// tag is a plain entry index
`define ROB_TAG_W 4

// data and address width
`define XLEN 32

// architectural register index
`define REG_IDX_W 5

`endif

/* logic/rob_pkg.sv */
`default_nettype none

`include "rob_config.svh"

package rob_pkg;

    // entry kind, decides what commit does with it
    typedef enum logic [1:0] {
        OP_REG    = 2'd0,
        OP_STORE  = 2'd1,
        OP_BRANCH = 2'd2,
        OP_JALR   = 2'd3
    } rob_op_e;

    // store width towards the load/store buffer
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // one instruction from the decoder
    typedef struct packed {
        rob_op_e                 op;
        logic [`REG_IDX_W-1:0]   rd;
        logic [`XLEN-1:0]        pc;
        logic                    predicted_taken;
        mem_size_e               size;
    } dispatch_t;

    // alu or load result, target only matters for branch and jalr
    typedef struct packed {
        logic                    valid;
        logic [`ROB_TAG_W-1:0]   tag;
        logic [`XLEN-1:0]        value;
        logic [`XLEN-1:0]        target;
    } wb_t;

    // store address and data, both known
    typedef struct packed {
        logic                    valid;
        logic [`ROB_TAG_W-1:0]   tag;
        logic [`XLEN-1:0]        addr;
        logic [`XLEN-1:0]        data;
    } store_wb_t;

    // stored entry; for a store, value holds the store data
    typedef struct packed {
        rob_op_e                 op;
        logic [`REG_IDX_W-1:0]   rd;
        logic [`XLEN-1:0]        pc;
        logic                    predicted_taken;
        mem_size_e               size;
        logic                    ready;
        logic [`XLEN-1:0]        value;
        logic [`XLEN-1:0]        target;
        logic [`XLEN-1:0]        addr;
    } rob_entry_t;

    typedef struct packed {
        logic                    valid;
        logic [`REG_IDX_W-1:0]   rd;
        logic [`ROB_TAG_W-1:0]   tag;
        logic [`XLEN-1:0]        value;
    } reg_commit_t;

    typedef struct packed {
        logic                    valid;
        mem_size_e               size;
        logic [`XLEN-1:0]        addr;
        logic [`XLEN-1:0]        data;
    } store_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`XLEN-1:0]        pc;
    } redirect_t;

endpackage

`default_nettype wire

/* logic/rob_queue_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_queue_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  dispatch_valid,
    input  logic                  pop,
    input  logic                  flush,
    output logic                  dispatch_ready,
    output logic                  push,
    output logic [`ROB_TAG_W-1:0] head,
    output logic [`ROB_TAG_W-1:0] tail,
    output logic [`ROB_TAG_W-1:0] alloc_tag,
    output logic                  empty
);

    // one extra bit so a full buffer is distinct from an empty one
    logic [`ROB_TAG_W:0] count;
    logic                full;

    assign full  = (count == (`ROB_TAG_W+1)'(`ROB_DEPTH));
    assign empty = (count == '0);

    // no allocation in the flush cycle, that slot is about to vanish
    assign dispatch_ready = !full && !flush;
    assign push           = dispatch_valid && dispatch_ready;
    assign alloc_tag      = tail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // mispredict or jalr, drop everything younger too
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // pointers wrap at the tag width
            if (pop) begin
                head <= head + 1'b1;
            end
            if (push) begin
                tail <= tail + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // occupancy bound
    assert property (@(posedge clk) disable iff (!rst_n)
        count <= (`ROB_TAG_W+1)'(`ROB_DEPTH));

    // commit unit must never pop an empty queue
    assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> !empty);

endmodule

`default_nettype wire

/* logic/rob_entry_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_entry_array (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    push,
    input  logic [`ROB_TAG_W-1:0]   tail,
    input  rob_pkg::dispatch_t      dispatch,
    input  rob_pkg::wb_t            alu_wb,
    input  rob_pkg::wb_t            load_wb,
    input  rob_pkg::store_wb_t      store_wb,
    input  logic                    flush,
    input  logic [`ROB_TAG_W-1:0]   head,
    input  logic [`ROB_TAG_W-1:0]   rs1_tag,
    input  logic [`ROB_TAG_W-1:0]   rs2_tag,
    output rob_pkg::rob_entry_t     head_entry,
    output logic                    rs1_ready,
    output logic [`XLEN-1:0]        rs1_value,
    output logic                    rs2_ready,
    output logic [`XLEN-1:0]        rs2_value
);

    // payload storage, the ready bits live apart in ready_q
    rob_pkg::rob_entry_t      entry_mem [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0]    ready_q;

    // per-entry decode of the write ports
    logic [`ROB_DEPTH-1:0]    push_hit;
    logic [`ROB_DEPTH-1:0]    wb_hit;
    logic [`ROB_DEPTH-1:0]    st_hit;
    rob_pkg::wb_t             wb_sel [`ROB_DEPTH];

    always_comb begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            push_hit[i] = push && (tail == `ROB_TAG_W'(i));
            st_hit[i]   = store_wb.valid && (store_wb.tag == `ROB_TAG_W'(i));
            // alu and load never target the same tag in one cycle
            if (alu_wb.valid && (alu_wb.tag == `ROB_TAG_W'(i))) begin
                wb_sel[i] = alu_wb;
                wb_hit[i] = 1'b1;
            end else begin
                wb_sel[i] = load_wb;
                wb_hit[i] = load_wb.valid && (load_wb.tag == `ROB_TAG_W'(i));
            end
        end
    end

    // payload writes
    always_ff @(posedge clk) begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            if (push_hit[i]) begin
                entry_mem[i].op              <= dispatch.op;
                entry_mem[i].rd              <= dispatch.rd;
                entry_mem[i].pc              <= dispatch.pc;
                entry_mem[i].predicted_taken <= dispatch.predicted_taken;
                entry_mem[i].size            <= dispatch.size;
            end
            if (wb_hit[i]) begin
                entry_mem[i].value  <= wb_sel[i].value;
                entry_mem[i].target <= wb_sel[i].target;
            end
            // store data goes where a register result would
            if (st_hit[i]) begin
                entry_mem[i].addr  <= store_wb.addr;
                entry_mem[i].value <= store_wb.data;
            end
        end
    end

    // ready bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= '0;
        end else if (flush) begin
            ready_q <= '0;
        end else begin
            // freshly allocated slot starts not ready
            ready_q <= (ready_q & ~push_hit) | wb_hit | st_hit;
        end
    end

    // head view for the commit unit
    always_comb begin
        head_entry       = entry_mem[head];
        head_entry.ready = ready_q[head];
    end

    // operand lookup, no bypass of this cycle's writeback
    assign rs1_ready = ready_q[rs1_tag];
    assign rs1_value = entry_mem[rs1_tag].value;
    assign rs2_ready = ready_q[rs2_tag];
    assign rs2_value = entry_mem[rs2_tag].value;

    // a slot is never written back while it is being allocated
    assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !((alu_wb.valid && alu_wb.tag == tail) ||
                   (load_wb.valid && load_wb.tag == tail) ||
                   (store_wb.valid && store_wb.tag == tail)));

endmodule

`default_nettype wire

/* logic/rob_commit_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_commit_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    empty,
    input  logic [`ROB_TAG_W-1:0]   head,
    input  rob_pkg::rob_entry_t     head_entry,
    input  logic                    store_done,
    output logic                    pop,
    output logic                    flush,
    output rob_pkg::reg_commit_t    reg_commit,
    output rob_pkg::store_req_t     store_req,
    output rob_pkg::redirect_t      redirect
);

    logic             fired_q;
    logic             commit_fire;
    logic             taken;
    logic             mispredict;
    logic [`XLEN-1:0] fall_through;

    // bit 0 of a branch result means taken
    assign taken        = head_entry.value[0];
    assign mispredict   = (taken != head_entry.predicted_taken);
    assign fall_through = head_entry.pc + `XLEN'(4);

    // one commit every other cycle at most
    // a pending store blocks everything behind it
    assign commit_fire = !empty && head_entry.ready && !store_req.valid && !fired_q;

    assign pop = commit_fire;

    // wrong-path or jalr, throw away the rest of the buffer
    assign flush = commit_fire &&
                   ((head_entry.op == rob_pkg::OP_JALR) ||
                    ((head_entry.op == rob_pkg::OP_BRANCH) && mispredict));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fired_q    <= 1'b0;
            reg_commit <= '0;
            store_req  <= '0;
            redirect   <= '0;
        end else begin
            fired_q <= commit_fire;
            // single-cycle pulses
            reg_commit.valid <= 1'b0;
            redirect.valid   <= 1'b0;

            // store request drops the cycle after the buffer takes it
            if (store_req.valid && store_done) begin
                store_req.valid <= 1'b0;
            end

            if (commit_fire) begin
                case (head_entry.op)
                    rob_pkg::OP_REG: begin
                        reg_commit.valid <= 1'b1;
                        reg_commit.rd    <= head_entry.rd;
                        reg_commit.tag   <= head;
                        reg_commit.value <= head_entry.value;
                    end
                    rob_pkg::OP_STORE: begin
                        store_req.valid <= 1'b1;
                        store_req.size  <= head_entry.size;
                        store_req.addr  <= head_entry.addr;
                        store_req.data  <= head_entry.value;
                    end
                    rob_pkg::OP_BRANCH: begin
                        // correct prediction just retires quietly
                        if (mispredict) begin
                            redirect.valid <= 1'b1;
                            redirect.pc    <= taken ? head_entry.target : fall_through;
                        end
                    end
                    rob_pkg::OP_JALR: begin
                        // link value to rd, then jump
                        reg_commit.valid <= 1'b1;
                        reg_commit.rd    <= head_entry.rd;
                        reg_commit.tag   <= head;
                        reg_commit.value <= head_entry.value;
                        redirect.valid   <= 1'b1;
                        redirect.pc      <= head_entry.target;
                    end
                    default: begin
                        reg_commit.valid <= 1'b0;
                    end
                endcase
            end
        end
    end

    // held store request must not move until accepted
    assert property (@(posedge clk) disable iff (!rst_n)
        (store_req.valid && !store_done) |=> (store_req.valid && $stable(store_req)));

endmodule

`default_nettype wire

/* logic/rob_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_top (
    input  logic                    clk,
    input  logic                    rst_n,
    // decoder side
    input  logic                    dispatch_valid,
    input  rob_pkg::dispatch_t      dispatch,
    output logic                    dispatch_ready,
    output logic [`ROB_TAG_W-1:0]   alloc_tag,
    // results
    input  rob_pkg::wb_t            alu_wb,
    input  rob_pkg::wb_t            load_wb,
    input  rob_pkg::store_wb_t      store_wb,
    // operand lookup
    input  logic [`ROB_TAG_W-1:0]   rs1_tag,
    input  logic [`ROB_TAG_W-1:0]   rs2_tag,
    output logic                    rs1_ready,
    output logic [`XLEN-1:0]        rs1_value,
    output logic                    rs2_ready,
    output logic [`XLEN-1:0]        rs2_value,
    // commit side
    output rob_pkg::reg_commit_t    reg_commit,
    output rob_pkg::store_req_t     store_req,
    input  logic                    store_done,
    output rob_pkg::redirect_t      redirect
);

    logic                  push;
    logic                  pop;
    logic                  flush;
    logic                  empty;
    logic [`ROB_TAG_W-1:0] head;
    logic [`ROB_TAG_W-1:0] tail;
    rob_pkg::rob_entry_t   head_entry;

    rob_queue_ctrl u_queue_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .pop            (pop),
        .flush          (flush),
        .dispatch_ready (dispatch_ready),
        .push           (push),
        .head           (head),
        .tail           (tail),
        .alloc_tag      (alloc_tag),
        .empty          (empty)
    );

    rob_entry_array u_entry_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .tail       (tail),
        .dispatch   (dispatch),
        .alu_wb     (alu_wb),
        .load_wb    (load_wb),
        .store_wb   (store_wb),
        .flush      (flush),
        .head       (head),
        .rs1_tag    (rs1_tag),
        .rs2_tag    (rs2_tag),
        .head_entry (head_entry),
        .rs1_ready  (rs1_ready),
        .rs1_value  (rs1_value),
        .rs2_ready  (rs2_ready),
        .rs2_value  (rs2_value)
    );

    rob_commit_unit u_commit_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .empty      (empty),
        .head       (head),
        .head_entry (head_entry),
        .store_done (store_done),
        .pop        (pop),
        .flush      (flush),
        .reg_commit (reg_commit),
        .store_req  (store_req),
        .redirect   (redirect)
    );

endmodule

`default_nettype wire

/* verif/rob_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_tb;

    logic                  clk;
    logic                  rst_n;
    logic                  dispatch_valid;
    rob_pkg::dispatch_t    dispatch;
    logic                  dispatch_ready;
    logic [`ROB_TAG_W-1:0] alloc_tag;
    rob_pkg::wb_t          alu_wb;
    rob_pkg::wb_t          load_wb;
    rob_pkg::store_wb_t    store_wb;
    logic [`ROB_TAG_W-1:0] rs1_tag;
    logic [`ROB_TAG_W-1:0] rs2_tag;
    logic                  rs1_ready;
    logic [`XLEN-1:0]      rs1_value;
    logic                  rs2_ready;
    logic [`XLEN-1:0]      rs2_value;
    rob_pkg::reg_commit_t  reg_commit;
    rob_pkg::store_req_t   store_req;
    logic                  store_done;
    rob_pkg::redirect_t    redirect;

    // reference model, one slot per tag
    rob_pkg::dispatch_t    m_disp [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] m_ready;
    logic [`XLEN-1:0]      m_value [`ROB_DEPTH];
    logic [`XLEN-1:0]      m_target [`ROB_DEPTH];
    logic [`XLEN-1:0]      m_addr [`ROB_DEPTH];
    // live tags, oldest first
    logic [`ROB_TAG_W-1:0] order [$];
    logic [`ROB_TAG_W-1:0] m_tail;

    integer                seed = 32'h80c3_82ef;
    int                    errors;
    int                    commits;
    int                    st_wait;
    logic                  hold_wb;
    logic                  reg_only;
    logic                  dispatch_en;
    // a commit output was seen last cycle
    logic                  pulse_q;
    // store request under observation, and its first value
    logic                  st_active;
    logic                  st_seen;
    rob_pkg::store_req_t   st_exp;

    rob_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .alloc_tag      (alloc_tag),
        .alu_wb         (alu_wb),
        .load_wb        (load_wb),
        .store_wb       (store_wb),
        .rs1_tag        (rs1_tag),
        .rs2_tag        (rs2_tag),
        .rs1_ready      (rs1_ready),
        .rs1_value      (rs1_value),
        .rs2_ready      (rs2_ready),
        .rs2_value      (rs2_value),
        .reg_commit     (reg_commit),
        .store_req      (store_req),
        .store_done     (store_done),
        .redirect       (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_value(input string name, input logic [`XLEN-1:0] exp,
                                input logic [`XLEN-1:0] act);
        errors++;
        $display("[FAIL] %s expected %0h actual %0h at %0t", name, exp, act, $time);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR: %s at %0t", msg, $time);
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // correctly predicted branches retire without any output
    function automatic void drop_quiet_branches();
        while (order.size() != 0 && m_ready[order[0]] &&
               m_disp[order[0]].op == rob_pkg::OP_BRANCH &&
               m_value[order[0]][0] == m_disp[order[0]].predicted_taken)
            void'(order.pop_front());
    endfunction

    // random pending tag; kind 0 alu, 1 load, 2 store; -1 when none
    function automatic int pick_pending(input int kind, input int skip);
        int cand [$];
        foreach (order[i]) begin
            if (!m_ready[order[i]] && order[i] != skip &&
                !(dispatch_valid && dispatch_ready && order[i] == alloc_tag) &&
                ((kind == 0 && m_disp[order[i]].op != rob_pkg::OP_STORE) ||
                 (kind == 1 && m_disp[order[i]].op == rob_pkg::OP_REG) ||
                 (kind == 2 && m_disp[order[i]].op == rob_pkg::OP_STORE)))
                cand.push_back(order[i]);
        end
        if (cand.size() == 0)
            return -1;
        return cand[rand_below(cand.size())];
    endfunction

    task automatic drive_inputs();
        int r;
        int a;
        int l;
        int s;
        alu_wb = '0;
        load_wb = '0;
        store_wb = '0;
        store_done = 1'b0;
        dispatch_valid = dispatch_en && (rand_below(4) != 0);
        r = rand_below(16);
        if (reg_only || r < 8)
            dispatch.op = rob_pkg::OP_REG;
        else if (r < 11)
            dispatch.op = rob_pkg::OP_STORE;
        else if (r < 15)
            dispatch.op = rob_pkg::OP_BRANCH;
        else
            dispatch.op = rob_pkg::OP_JALR;
        dispatch.rd = `REG_IDX_W'(rand_below(32));
        dispatch.pc = $random(seed) & 32'hffff_fffc;
        dispatch.predicted_taken = rand_below(2);
        dispatch.size = rob_pkg::mem_size_e'(rand_below(3));
        // results out of order, never onto the slot being allocated
        a = (!hold_wb && rand_below(2) == 0) ? pick_pending(0, -1) : -1;
        l = (!hold_wb && rand_below(2) == 0) ? pick_pending(1, a) : -1;
        s = (!hold_wb && rand_below(2) == 0) ? pick_pending(2, -1) : -1;
        if (a >= 0) begin
            alu_wb.valid = 1'b1;
            alu_wb.tag = a;
            alu_wb.value = $random(seed);
            alu_wb.target = $random(seed) & 32'hffff_fffc;
        end
        if (l >= 0) begin
            load_wb.valid = 1'b1;
            load_wb.tag = l;
            load_wb.value = $random(seed);
            load_wb.target = $random(seed);
        end
        if (s >= 0) begin
            store_wb.valid = 1'b1;
            store_wb.tag = s;
            store_wb.addr = $random(seed);
            store_wb.data = $random(seed);
        end
        rs1_tag = rand_below(`ROB_DEPTH);
        rs2_tag = rand_below(`ROB_DEPTH);
        // store buffer answers 0 to 5 cycles late
        if (store_req.valid) begin
            if (!st_seen) begin
                st_seen = 1'b1;
                st_wait = rand_below(6);
            end
            if (st_wait == 0) begin
                store_done = 1'b1;
                st_seen = 1'b0;
            end else begin
                st_wait--;
            end
        end
    endtask

    task automatic sample_outputs();
        logic                  pulse;
        logic [`ROB_TAG_W-1:0] t;
        logic [`XLEN-1:0]      exp_pc;
        rob_pkg::rob_op_e      kind;
        pulse = reg_commit.valid || redirect.valid || (store_req.valid && !st_active);
        if (pulse && pulse_q)
            report_error("commit outputs in two adjacent cycles");
        if (st_active && store_req.valid && store_req !== st_exp)
            report_error("store request changed while outstanding");
        if (st_active && (reg_commit.valid || redirect.valid))
            report_error("commit while a store was outstanding");
        pulse_q = pulse;
        if (pulse) begin
            commits++;
            // the output pattern tells the kind of the retired entry
            if (reg_commit.valid && redirect.valid)
                kind = rob_pkg::OP_JALR;
            else if (reg_commit.valid)
                kind = rob_pkg::OP_REG;
            else if (redirect.valid)
                kind = rob_pkg::OP_BRANCH;
            else
                kind = rob_pkg::OP_STORE;
            drop_quiet_branches();
            if (order.size() == 0) begin
                report_error("commit output with no live entry in the model");
            end else begin
                t = order.pop_front();
                if (!m_ready[t])
                    report_error("commit of an entry that had no result");
                if (m_disp[t].op != kind) begin
                    report_value("commit kind", m_disp[t].op, kind);
                end else if (kind == rob_pkg::OP_STORE) begin
                    if (store_req.size !== m_disp[t].size)
                        report_value("store size", m_disp[t].size, store_req.size);
                    if (store_req.addr !== m_addr[t])
                        report_value("store addr", m_addr[t], store_req.addr);
                    if (store_req.data !== m_value[t])
                        report_value("store data", m_value[t], store_req.data);
                end else if (kind == rob_pkg::OP_BRANCH) begin
                    // bit 0 of the result is the taken flag
                    exp_pc = m_value[t][0] ? m_target[t] : m_disp[t].pc + 32'd4;
                    if (redirect.pc !== exp_pc)
                        report_value("branch redirect pc", exp_pc, redirect.pc);
                end else begin
                    if (reg_commit.rd !== m_disp[t].rd)
                        report_value("commit rd", m_disp[t].rd, reg_commit.rd);
                    if (reg_commit.tag !== t)
                        report_value("commit tag", t, reg_commit.tag);
                    if (reg_commit.value !== m_value[t])
                        report_value("commit value", m_value[t], reg_commit.value);
                    if (kind == rob_pkg::OP_JALR && redirect.pc !== m_target[t])
                        report_value("jalr redirect pc", m_target[t], redirect.pc);
                end
            end
        end
        // flush took effect on the same edge
        if (redirect.valid) begin
            order.delete();
            m_ready = '0;
            m_tail = '0;
        end
        if (store_req.valid && !st_active)
            st_exp = store_req;
        st_active = store_req.valid;
        if (alloc_tag !== m_tail)
            report_value("alloc tag", m_tail, alloc_tag);
        if (rs1_ready !== m_ready[rs1_tag])
            report_value("rs1 ready", m_ready[rs1_tag], rs1_ready);
        if (m_ready[rs1_tag] && rs1_value !== m_value[rs1_tag])
            report_value("rs1 value", m_value[rs1_tag], rs1_value);
        if (rs2_ready !== m_ready[rs2_tag])
            report_value("rs2 ready", m_ready[rs2_tag], rs2_ready);
        if (m_ready[rs2_tag] && rs2_value !== m_value[rs2_tag])
            report_value("rs2 value", m_value[rs2_tag], rs2_value);
        // transfers that land on the next edge
        if (dispatch_valid && dispatch_ready) begin
            drop_quiet_branches();
            if (order.size() == `ROB_DEPTH)
                report_error("dispatch accepted into a full buffer");
            m_disp[m_tail] = dispatch;
            m_ready[m_tail] = 1'b0;
            order.push_back(m_tail);
            m_tail++;
        end
        if (alu_wb.valid) begin
            m_ready[alu_wb.tag] = 1'b1;
            m_value[alu_wb.tag] = alu_wb.value;
            m_target[alu_wb.tag] = alu_wb.target;
        end
        if (load_wb.valid) begin
            m_ready[load_wb.tag] = 1'b1;
            m_value[load_wb.tag] = load_wb.value;
            m_target[load_wb.tag] = load_wb.target;
        end
        if (store_wb.valid) begin
            m_ready[store_wb.tag] = 1'b1;
            m_value[store_wb.tag] = store_wb.data;
            m_addr[store_wb.tag] = store_wb.addr;
        end
    endtask

    // drive 1 ns after the edge, look 2 ns later
    task automatic step_cycle();
        @(posedge clk);
        #1;
        drive_inputs();
        #2;
        sample_outputs();
    endtask

    initial begin
        int n;
        int c0;
        rst_n = 1'b0;
        dispatch_valid = 1'b0;
        dispatch = '0;
        alu_wb = '0;
        load_wb = '0;
        store_wb = '0;
        rs1_tag = '0;
        rs2_tag = '0;
        store_done = 1'b0;
        m_ready = '0;
        m_tail = '0;
        hold_wb = 1'b1;
        reg_only = 1'b1;
        dispatch_en = 1'b0;
        pulse_q = 1'b0;
        st_active = 1'b0;
        st_seen = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        #2;
        if (dispatch_ready !== 1'b1)
            report_value("reset dispatch_ready", 1, dispatch_ready);
        if (alloc_tag !== '0)
            report_value("reset alloc_tag", 0, alloc_tag);
        if (reg_commit.valid !== 1'b0 || store_req.valid !== 1'b0 || redirect.valid !== 1'b0)
            report_error("a valid output is high after reset");

        // fill every slot, results withheld
        dispatch_en = 1'b1;
        n = 0;
        while (order.size() < `ROB_DEPTH && n < 200) begin
            step_cycle();
            n++;
        end
        if (order.size() < `ROB_DEPTH)
            report_error("timeout while filling the buffer");
        for (n = 0; n < 8; n++) begin
            step_cycle();
            if (dispatch_ready !== 1'b0)
                report_value("full dispatch_ready", 0, dispatch_ready);
        end

        // results return, first commit frees the oldest slot
        c0 = commits;
        hold_wb = 1'b0;
        n = 0;
        do begin
            step_cycle();
            n++;
        end while (dispatch_ready !== 1'b1 && n < 200);
        if (dispatch_ready !== 1'b1)
            report_error("timeout waiting for a free slot");
        if (commits == c0)
            report_error("a slot was freed without any commit");

        // mixed random traffic
        reg_only = 1'b0;
        for (n = 0; n < 4000; n++)
            step_cycle();

        // drain, stores and quiet branches included
        dispatch_en = 1'b0;
        n = 0;
        drop_quiet_branches();
        while ((order.size() != 0 || store_req.valid) && n < 500) begin
            step_cycle();
            drop_quiet_branches();
            n++;
        end
        if (order.size() != 0 || store_req.valid)
            report_error("timeout while draining the buffer");

        $display("commits seen: %0d, errors: %0d", commits, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
logic/rob_pkg.sv
logic/rob_queue_ctrl.sv
logic/rob_entry_array.sv
logic/rob_commit_unit.sv
logic/rob_top.sv
verif/rob_tb.sv

/* Bender.yml */
package:
  name: rob

sources:
  - include_dirs:
      - include
    files:
      - logic/rob_pkg.sv
      - logic/rob_queue_ctrl.sv
      - logic/rob_entry_array.sv
      - logic/rob_commit_unit.sv
      - logic/rob_top.sv
      - target: simulation
        files:
          - verif/rob_tb.sv
